// ==== source/cp0_pkg.sv ====
package cp0_pkg;

   // cp0 register numbers
   localparam logic [4:0] cp0_reg_badvaddr = 5'd8;
   localparam logic [4:0] cp0_reg_count    = 5'd9;
   localparam logic [4:0] cp0_reg_compare  = 5'd11;
   localparam logic [4:0] cp0_reg_status   = 5'd12;
   localparam logic [4:0] cp0_reg_cause    = 5'd13;
   localparam logic [4:0] cp0_reg_epc      = 5'd14;
   localparam logic [4:0] cp0_reg_prid     = 5'd15;
   localparam logic [4:0] cp0_reg_config   = 5'd16;

   // status fields
   localparam int unsigned ie_bit  = 0;   // global interrupt enable
   localparam int unsigned exl_bit = 1;   // exception level
   localparam int unsigned bev_bit = 22;  // boot vectors
   localparam int unsigned im_hi   = 15;
   localparam int unsigned im_lo   = 8;

   // cause fields
   localparam int unsigned bd_bit      = 31;  // branch delay
   localparam int unsigned ti_bit      = 30;  // timer pending
   localparam int unsigned ip_hi       = 15;  // hw lines ip7..ip2
   localparam int unsigned ip_lo       = 10;
   localparam int unsigned sw_ip_hi    = 9;   // software ip1..ip0
   localparam int unsigned sw_ip_lo    = 8;
   localparam int unsigned exc_code_hi = 6;
   localparam int unsigned exc_code_lo = 2;

   // committed exception, one per instruction
   typedef enum logic [3:0] {
      exc_none,
      exc_int,
      exc_adel,
      exc_ades,
      exc_ri,
      exc_sys,
      exc_bp,
      exc_ov,
      exc_eret
   } exc_type_e;

   // ExcCode values written to cause
   localparam logic [4:0] exc_code_int  = 5'd0;
   localparam logic [4:0] exc_code_adel = 5'd4;
   localparam logic [4:0] exc_code_ades = 5'd5;
   localparam logic [4:0] exc_code_sys  = 5'd8;
   localparam logic [4:0] exc_code_bp   = 5'd9;
   localparam logic [4:0] exc_code_ri   = 5'd10;
   localparam logic [4:0] exc_code_ov   = 5'd12;

   // reset contents
   localparam logic [31:0] status_reset = 32'h1 << bev_bit;
   localparam logic [31:0] config_reset = 32'h0000_8000;
   localparam logic [31:0] prid_reset   = 32'h004c_0102;

   // single entry point for all exceptions and interrupts
   localparam logic [31:0] exc_vector = 32'hbfc0_0380;

endpackage

// ==== source/exc_commit_if.sv ====
interface exc_commit_if import cp0_pkg::*; ();

   logic        en;             // one cycle commit strobe
   exc_type_e   exc_type;
   logic [31:0] pc;             // pc of the memory stage instruction
   logic        in_delay_slot;
   logic [31:0] badvaddr;

   modport arbiter (
      output en,
      output exc_type,
      output pc,
      output in_delay_slot,
      output badvaddr
   );

   // receiving side, the cp0 register file
   modport regs (
      input en,
      input exc_type,
      input pc,
      input in_delay_slot,
      input badvaddr
   );

endinterface

// ==== source/int_ctrl.sv ====
module int_ctrl import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [5:0]  ext_int_i,
   input  logic        timer_int_i,
   input  logic [31:0] status_i,
   input  logic [1:0]  cause_sw_i,
   input  logic        valid_i,
   output logic [5:0]  hw_ip_o,
   output logic        int_take_o
);

   logic [5:0] ext_q;    // sampled external lines
   logic [7:0] pending;  // ip7..ip0 after masking with im

   always_ff @(posedge clk) begin
      if (rst) begin
         ext_q <= '0;
      end else begin
         ext_q <= ext_int_i;
      end
   end

   // timer shares ip7 with the top external line
   assign hw_ip_o = {ext_q[5] | timer_int_i, ext_q[4:0]};

   assign pending = {hw_ip_o, cause_sw_i} & status_i[im_hi:im_lo];

   // only taken on a real instruction, outside exception level
   assign int_take_o = valid_i & (|pending) & status_i[ie_bit] & ~status_i[exl_bit];

   // a taken interrupt raises exl, so the handler is never interrupted
   a_exl_after_int: assert property (
      @(posedge clk) disable iff (rst)
      int_take_o |=> status_i[exl_bit]
   ) else $error("status.exl not set after an interrupt was taken");

endmodule

// ==== source/exc_arbiter.sv ====
module exc_arbiter import cp0_pkg::*; (
   input  logic          valid_i,
   input  logic [31:0]   pc_i,
   input  logic          in_delay_slot_i,
   input  logic [31:0]   badvaddr_i,
   input  logic          adel_i,
   input  logic          ades_i,
   input  logic          ri_i,
   input  logic          sys_i,
   input  logic          bp_i,
   input  logic          ov_i,
   input  logic          eret_i,
   input  logic          int_take_i,
   input  logic [31:0]   epc_i,
   exc_commit_if.arbiter commit,
   output logic          flush_o,
   output logic [31:0]   new_pc_o
);

   exc_type_e sel_type;
   logic      any_exc;    // something other than eret
   logic      take_eret;

   // fixed priority, flags only count for a valid instruction
   always_comb begin
      sel_type = exc_none;
      if (int_take_i) begin
         sel_type = exc_int;   // int_take already includes valid
      end else if (valid_i) begin
         if (adel_i) begin
            sel_type = exc_adel;
         end else if (ri_i) begin
            sel_type = exc_ri;
         end else if (ov_i) begin
            sel_type = exc_ov;
         end else if (sys_i) begin
            sel_type = exc_sys;
         end else if (bp_i) begin
            sel_type = exc_bp;
         end else if (ades_i) begin
            sel_type = exc_ades;
         end else if (eret_i) begin
            sel_type = exc_eret;
         end
      end
   end

   assign take_eret = (sel_type == exc_eret);
   assign any_exc   = (sel_type != exc_none) && !take_eret;

   // commit toward the register file
   assign commit.en            = (sel_type != exc_none);
   assign commit.exc_type      = sel_type;
   assign commit.pc            = pc_i;
   assign commit.in_delay_slot = in_delay_slot_i;
   assign commit.badvaddr      = badvaddr_i;

   // redirect the fetch stage
   assign flush_o = any_exc | take_eret;

   always_comb begin
      new_pc_o = '0;
      if (take_eret) begin
         new_pc_o = epc_i;
      end else if (any_exc) begin
         new_pc_o = exc_vector;
      end
   end

endmodule

// ==== source/cp0_reg.sv ====
module cp0_reg import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   exc_commit_if.regs  commit,
   input  logic [5:0]  hw_ip_i,
   input  logic        we_i,       // mtc0
   input  logic [4:0]  waddr_i,
   input  logic [31:0] wdata_i,
   input  logic [4:0]  raddr_i,    // mfc0
   output logic [31:0] rdata_o,
   output logic [31:0] status_o,
   output logic [31:0] cause_o,
   output logic [31:0] epc_o,
   output logic        timer_int_o
);

   logic [32:0] count_q;   // lsb is the half rate prescaler
   logic [31:0] count;
   logic [31:0] compare_q;
   logic [31:0] status_q;
   logic [31:0] cause_q;
   logic [31:0] epc_q;
   logic [31:0] badvaddr_q;
   logic        timer_q;
   logic [31:0] exc_epc;
   logic        addr_exc;  // adel or ades

   function automatic logic [4:0] exc_code_of(exc_type_e t);
      logic [4:0] code;
      case (t)
         exc_adel: code = exc_code_adel;
         exc_ades: code = exc_code_ades;
         exc_ri:   code = exc_code_ri;
         exc_sys:  code = exc_code_sys;
         exc_bp:   code = exc_code_bp;
         exc_ov:   code = exc_code_ov;
         default:  code = exc_code_int;
      endcase
      return code;
   endfunction

   assign count = count_q[32:1];

   // a delay slot instruction restarts at its branch
   assign exc_epc  = commit.in_delay_slot ? commit.pc - 32'd4 : commit.pc;
   assign addr_exc = (commit.exc_type == exc_adel) || (commit.exc_type == exc_ades);

   always_ff @(posedge clk) begin
      if (rst) begin
         count_q     <= '0;
         compare_q   <= '0;
         status_q    <= status_reset;
         cause_q     <= '0;
         epc_q       <= '0;
         timer_q     <= 1'b0;
      end else begin
         count_q <= count_q + 33'd1;
         cause_q[ip_hi:ip_lo] <= hw_ip_i;   // second stage of the line sampling

         if (compare_q != '0 && count == compare_q) begin
            timer_q         <= 1'b1;
            cause_q[ti_bit] <= 1'b1;
         end

         if (commit.en) begin
            // exception wins, a same cycle mtc0 is lost
            if (commit.exc_type == exc_eret) begin
               status_q[exl_bit] <= 1'b0;
            end else begin
               epc_q                             <= exc_epc;
               cause_q[bd_bit]                   <= commit.in_delay_slot;
               cause_q[exc_code_hi:exc_code_lo]  <= exc_code_of(commit.exc_type);
               status_q[exl_bit]                 <= 1'b1;
            end
         end else if (we_i) begin
            case (waddr_i)
               cp0_reg_count: begin
                  count_q <= {wdata_i, 1'b0};
               end
               cp0_reg_compare: begin
                  compare_q       <= wdata_i;
                  timer_q         <= 1'b0;   // acknowledge timer
                  cause_q[ti_bit] <= 1'b0;
               end
               cp0_reg_status: begin
                  status_q[ie_bit]      <= wdata_i[ie_bit];
                  status_q[im_hi:im_lo] <= wdata_i[im_hi:im_lo];
               end
               cp0_reg_cause: begin
                  cause_q[sw_ip_hi:sw_ip_lo] <= wdata_i[sw_ip_hi:sw_ip_lo];
               end
               cp0_reg_epc: begin
                  epc_q <= wdata_i;
               end
               default: ;
            endcase
         end
      end
   end

   // faulting address, only for address errors
   always_ff @(posedge clk) begin
      if (commit.en && addr_exc) begin
         badvaddr_q <= commit.badvaddr;
      end
   end

   // mfc0, combinational
   always_comb begin
      rdata_o = '0;
      if (!rst) begin
         case (raddr_i)
            cp0_reg_count:    rdata_o = count;
            cp0_reg_compare:  rdata_o = compare_q;
            cp0_reg_status:   rdata_o = status_q;
            cp0_reg_cause:    rdata_o = cause_q;
            cp0_reg_epc:      rdata_o = epc_q;
            cp0_reg_prid:     rdata_o = prid_reset;
            cp0_reg_config:   rdata_o = config_reset;
            cp0_reg_badvaddr: rdata_o = badvaddr_q;
            default:          rdata_o = '0;
         endcase
      end
   end

   assign status_o    = status_q;
   assign cause_o     = cause_q;
   assign epc_o       = epc_q;
   assign timer_int_o = timer_q;

   // exl moves only through an exception or eret, never through mtc0
   a_exl_only_by_commit: assert property (
      @(posedge clk) disable iff (rst)
      !commit.en |=> $stable(status_q[exl_bit])
   ) else $error("status.exl changed without a commit");

endmodule

// ==== source/cp0_top.sv ====
module cp0_top import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [5:0]  ext_int_i,
   input  logic        valid_i,
   input  logic [31:0] pc_i,
   input  logic        in_delay_slot_i,
   input  logic [31:0] badvaddr_i,
   input  logic        adel_i,
   input  logic        ades_i,
   input  logic        ri_i,
   input  logic        sys_i,
   input  logic        bp_i,
   input  logic        ov_i,
   input  logic        eret_i,
   input  logic        we_i,
   input  logic [4:0]  waddr_i,
   input  logic [31:0] wdata_i,
   input  logic [4:0]  raddr_i,
   output logic [31:0] rdata_o,
   output logic [31:0] status_o,
   output logic [31:0] cause_o,
   output logic [31:0] epc_o,
   output logic        timer_int_o,
   output logic        flush_o,
   output logic [31:0] new_pc_o
);

   logic [5:0] hw_ip;
   logic       int_take;

   exc_commit_if commit ();

   int_ctrl u_int_ctrl (
      .clk         (clk),
      .rst         (rst),
      .ext_int_i   (ext_int_i),
      .timer_int_i (timer_int_o),
      .status_i    (status_o),
      .cause_sw_i  (cause_o[sw_ip_hi:sw_ip_lo]),
      .valid_i     (valid_i),
      .hw_ip_o     (hw_ip),
      .int_take_o  (int_take)
   );

   exc_arbiter u_exc_arbiter (
      .valid_i, .pc_i, .in_delay_slot_i, .badvaddr_i,
      .adel_i, .ades_i, .ri_i, .sys_i, .bp_i, .ov_i, .eret_i,
      .int_take_i (int_take),
      .epc_i      (epc_o),
      .commit     (commit.arbiter),
      .flush_o, .new_pc_o
   );

   cp0_reg u_cp0_reg (
      .clk, .rst,
      .commit  (commit.regs),
      .hw_ip_i (hw_ip),
      .we_i, .waddr_i, .wdata_i, .raddr_i, .rdata_o,
      .status_o, .cause_o, .epc_o, .timer_int_o
   );

endmodule

// ==== sim/cp0_checker.sv ====
module cp0_checker import cp0_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic [5:0]  ext_int_i,
   input  logic        valid_i,
   input  logic [31:0] pc_i,
   input  logic        in_delay_slot_i,
   input  logic [31:0] badvaddr_i,
   input  logic        adel_i,
   input  logic        ades_i,
   input  logic        ri_i,
   input  logic        sys_i,
   input  logic        bp_i,
   input  logic        ov_i,
   input  logic        eret_i,
   input  logic        we_i,
   input  logic [4:0]  waddr_i,
   input  logic [31:0] wdata_i,
   input  logic [4:0]  raddr_i,
   input  logic [31:0] rdata_o,
   input  logic [31:0] status_o,
   input  logic [31:0] cause_o,
   input  logic [31:0] epc_o,
   input  logic        timer_int_o,
   input  logic        flush_o,
   input  logic [31:0] new_pc_o,
   input  logic        exp_valid_i,   // table gives an expected mfc0 value
   input  logic [31:0] exp_rdata_i,
   output int          errors_o
);

   // reference state
   logic [5:0]  m_ext;
   logic [32:0] m_cnt;
   logic [31:0] m_cmp, m_epc, m_badv;
   logic        m_timer, m_ie, m_exl, m_bd, m_ti;
   logic [7:0]  m_im;
   logic [5:0]  m_hw;
   logic [1:0]  m_sw;
   logic [4:0]  m_code;
   logic [5:0]  hw_now;
   logic [31:0] m_status, m_cause;
   logic        exp_commit, exp_eret, exp_addr;
   logic [4:0]  exp_code;

   assign hw_now   = {m_ext[5] | m_timer, m_ext[4:0]};
   assign m_status = status_reset | {16'h0, m_im, 6'h0, m_exl, m_ie};
   assign m_cause  = {m_bd, m_ti, 14'h0, m_hw, m_sw, 1'b0, m_code, 2'b00};

   // expected commit for the current inputs
   always_comb begin
      exp_commit = 1'b0;
      exp_eret   = 1'b0;
      exp_addr   = 1'b0;
      exp_code   = exc_code_int;
      if (valid_i && |({hw_now, m_sw} & m_im) && m_ie && !m_exl) begin
         exp_commit = 1'b1;
      end else if (valid_i) begin
         exp_commit = adel_i | ades_i | ri_i | sys_i | bp_i | ov_i | eret_i;
         if (adel_i) begin
            exp_code = exc_code_adel;
            exp_addr = 1'b1;
         end else if (ri_i) begin
            exp_code = exc_code_ri;
         end else if (ov_i) begin
            exp_code = exc_code_ov;
         end else if (sys_i) begin
            exp_code = exc_code_sys;
         end else if (bp_i) begin
            exp_code = exc_code_bp;
         end else if (ades_i) begin
            exp_code = exc_code_ades;
            exp_addr = 1'b1;
         end else if (eret_i) begin
            exp_eret = 1'b1;
         end
      end
   end

   function automatic logic [31:0] model_read(logic [4:0] a);
      logic [31:0] v;
      case (a)
         cp0_reg_count:    v = m_cnt[32:1];
         cp0_reg_compare:  v = m_cmp;
         cp0_reg_status:   v = m_status;
         cp0_reg_cause:    v = m_cause;
         cp0_reg_epc:      v = m_epc;
         cp0_reg_prid:     v = prid_reset;
         cp0_reg_config:   v = config_reset;
         cp0_reg_badvaddr: v = m_badv;
         default:          v = '0;
      endcase
      return v;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         errors_o++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   always @(posedge clk) begin
      if (rst) begin
         m_ext <= '0;
         m_cnt <= '0;
         m_cmp <= '0;
         m_timer <= 1'b0;
         {m_ie, m_exl, m_bd, m_ti} <= '0;
         m_im <= '0;
         m_hw <= '0;
         m_sw <= '0;
         m_code <= '0;
         m_epc <= '0;
      end else begin
         m_ext <= ext_int_i;
         m_cnt <= m_cnt + 33'd1;
         m_hw  <= hw_now;
         if (m_cmp != 0 && m_cnt[32:1] == m_cmp) begin
            m_timer <= 1'b1;
            m_ti    <= 1'b1;
         end
         if (exp_commit) begin
            if (exp_eret) begin
               m_exl <= 1'b0;
            end else begin
               m_epc  <= in_delay_slot_i ? pc_i - 32'd4 : pc_i;
               m_bd   <= in_delay_slot_i;
               m_code <= exp_code;
               m_exl  <= 1'b1;
               if (exp_addr) m_badv <= badvaddr_i;
            end
         end else if (we_i) begin
            case (waddr_i)
               cp0_reg_count:   m_cnt <= {wdata_i, 1'b0};
               cp0_reg_compare: begin
                  m_cmp   <= wdata_i;
                  m_timer <= 1'b0;
                  m_ti    <= 1'b0;
               end
               cp0_reg_status: begin
                  m_ie <= wdata_i[ie_bit];
                  m_im <= wdata_i[im_hi:im_lo];
               end
               cp0_reg_cause:   m_sw <= wdata_i[sw_ip_hi:sw_ip_lo];
               cp0_reg_epc:     m_epc <= wdata_i;
               default: ;
            endcase
         end
      end
   end

   // outputs are settled half a cycle after the driving edge
   always @(negedge clk) begin
      if (!rst) begin
         check_value(flush_o, exp_commit, "flush_o");
         if (exp_commit) begin
            check_value(new_pc_o, exp_eret ? m_epc : exc_vector, "new_pc_o");
         end
         check_value(status_o, m_status, "status");
         check_value(cause_o, m_cause, "cause");
         check_value(epc_o, m_epc, "epc");
         check_value(timer_int_o, m_timer, "timer_int_o");
         check_value(rdata_o, model_read(raddr_i), "rdata_o vs model");
         if (exp_valid_i) check_value(rdata_o, exp_rdata_i, "rdata_o vs table");
      end
   end

   initial errors_o = 0;

endmodule

// ==== sim/cp0_tb.sv ====
module cp0_tb import cp0_pkg::*; ();

   localparam int op_idle = 0, op_write = 1, op_read = 2, op_exc = 3, op_wait = 4;
   localparam logic [6:0] fl_adel = 7'h40, fl_ades = 7'h20, fl_ri = 7'h10, fl_sys = 7'h08;
   localparam logic [6:0] fl_bp = 7'h04, fl_ov = 7'h02, fl_eret = 7'h01;

   typedef struct {
      int          op;
      logic [4:0]  addr;
      logic [31:0] data;    // write data, expected read or wait limit
      logic [6:0]  flags;   // adel ades ri sys bp ov eret
      logic [31:0] pc;
      logic        ds;
      logic [31:0] badv;
      logic [5:0]  ext;
   } entry_t;

   logic clk, rst, valid_i, in_delay_slot_i, we_i, exp_valid;
   logic adel_i, ades_i, ri_i, sys_i, bp_i, ov_i, eret_i;
   logic [5:0]  ext_int_i, ext_level;
   logic [31:0] pc_i, badvaddr_i, wdata_i, exp_rdata;
   logic [4:0]  waddr_i, raddr_i;
   logic [31:0] rdata_o, status_o, cause_o, epc_o, new_pc_o;
   logic        timer_int_o, flush_o;
   entry_t      table_q[$];
   int          checker_errors, tb_errors, cycles, limit, n;

   cp0_top UUT (.*);

   cp0_checker u_checker (.*, .exp_valid_i(exp_valid), .exp_rdata_i(exp_rdata),
                          .errors_o(checker_errors));

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic add_entry(int op, logic [4:0] a, logic [31:0] d, logic [6:0] f,
                            logic [31:0] pc, logic ds, logic [31:0] bv);
      entry_t e;
      e = '{op, a, d, f, pc, ds, bv, ext_level};
      table_q.push_back(e);
   endtask

   task automatic add_write(logic [4:0] a, logic [31:0] d);
      add_entry(op_write, a, d, 0, 0, 0, 0);
   endtask

   task automatic add_read(logic [4:0] a, logic [31:0] d);
      add_entry(op_read, a, d, 0, 0, 0, 0);
   endtask

   // one valid instruction, then back to the handler with eret
   task automatic add_exc_eret(logic [6:0] f, logic [31:0] pc, logic ds, logic [31:0] bv,
                               logic [31:0] cause_exp);
      add_entry(op_exc, 0, 0, f, pc, ds, bv);
      add_read(cp0_reg_cause, cause_exp);
      add_entry(op_exc, 0, 0, fl_eret, 32'h8000_0f00, 0, 0);
   endtask

   task automatic build_table();
      ext_level = '0;
      add_read(cp0_reg_status, 32'h0040_0000);   // reset values
      add_read(cp0_reg_config, 32'h0000_8000);
      add_read(cp0_reg_prid, 32'h004c_0102);
      add_read(cp0_reg_epc, 32'h0);
      add_read(cp0_reg_cause, 32'h0);
      add_write(cp0_reg_status, 32'hffff_ffff);
      add_read(cp0_reg_status, 32'h0040_ff01);   // exl not writable
      add_write(cp0_reg_status, 32'h0);
      add_write(cp0_reg_cause, 32'hffff_ffff);
      add_read(cp0_reg_cause, 32'h0000_0300);
      add_write(cp0_reg_cause, 32'h0);
      add_write(cp0_reg_epc, 32'h1234_5678);
      add_read(cp0_reg_epc, 32'h1234_5678);
      add_write(cp0_reg_compare, 32'h0000_0100);
      add_read(cp0_reg_compare, 32'h0000_0100);
      // address error load, full state inspection
      add_entry(op_exc, 0, 0, fl_adel, 32'h8000_0100, 0, 32'h0000_0003);
      add_read(cp0_reg_cause, 32'h0000_0010);
      add_read(cp0_reg_epc, 32'h8000_0100);
      add_read(cp0_reg_badvaddr, 32'h0000_0003);
      add_write(cp0_reg_status, 32'h0);
      add_read(cp0_reg_status, 32'h0040_0002);
      add_entry(op_exc, 0, 0, fl_eret, 0, 0, 0);
      add_read(cp0_reg_status, 32'h0040_0000);
      add_exc_eret(fl_ri, 32'h8000_0200, 1, 32'hdead_beef, 32'h8000_0028);
      add_read(cp0_reg_epc, 32'h8000_01fc);
      add_read(cp0_reg_badvaddr, 32'h0000_0003);
      add_exc_eret(fl_ov, 32'h8000_0300, 0, 0, 32'h0000_0030);
      add_exc_eret(fl_sys, 32'h8000_0304, 0, 0, 32'h0000_0020);
      add_exc_eret(fl_bp, 32'h8000_0308, 0, 0, 32'h0000_0024);
      add_exc_eret(fl_ades, 32'h8000_0400, 0, 32'h10, 32'h0000_0014);
      add_read(cp0_reg_badvaddr, 32'h0000_0010);
      // several flags at once
      add_exc_eret(fl_ri | fl_ov | fl_sys | fl_eret, 32'h8000_0500, 0, 0, 32'h0000_0028);
      add_exc_eret(fl_ades | fl_bp, 32'h8000_0504, 0, 0, 32'h0000_0024);
      // external line 0 on ip2
      add_write(cp0_reg_status, 32'h0000_0401);
      ext_level = 6'h01;
      add_entry(op_idle, 0, 0, 0, 0, 0, 0);
      add_entry(op_idle, 0, 0, 0, 0, 0, 0);
      add_entry(op_exc, 0, 0, 0, 32'h8000_0600, 0, 0);
      add_read(cp0_reg_cause, 32'h0000_0400);
      add_read(cp0_reg_status, 32'h0040_0403);
      add_entry(op_exc, 0, 0, 0, 32'h8000_0604, 0, 0);   // masked by exl
      ext_level = 6'h00;
      add_entry(op_idle, 0, 0, 0, 0, 0, 0);
      add_entry(op_idle, 0, 0, 0, 0, 0, 0);
      add_entry(op_exc, 0, 0, fl_eret, 0, 0, 0);
      add_read(cp0_reg_status, 32'h0040_0401);
      // software interrupt on ip0
      add_write(cp0_reg_status, 32'h0000_0101);
      add_write(cp0_reg_cause, 32'h0000_0100);
      add_entry(op_exc, 0, 0, 0, 32'h8000_0700, 0, 0);
      add_read(cp0_reg_cause, 32'h0000_0100);
      add_write(cp0_reg_cause, 32'h0);
      add_entry(op_exc, 0, 0, fl_eret, 0, 0, 0);
      add_write(cp0_reg_status, 32'h0);
      add_read(cp0_reg_status, 32'h0040_0000);
      // timer, compare five ticks ahead
      add_write(cp0_reg_count, 32'h0);
      add_write(cp0_reg_compare, 32'h5);
      add_entry(op_wait, 0, 2 * 5 + 2, 0, 0, 0, 0);
      add_write(cp0_reg_compare, 32'h0);
      add_entry(op_idle, 0, 0, 0, 0, 0, 0);   // ip7 follows the timer one cycle late
      add_read(cp0_reg_cause, 32'h0);
   endtask

   task automatic drive_entry(entry_t e);
      ext_int_i <= e.ext;
      valid_i <= (e.op == op_exc);
      {adel_i, ades_i, ri_i, sys_i, bp_i, ov_i, eret_i} <= e.flags;
      pc_i <= e.pc;
      in_delay_slot_i <= e.ds;
      badvaddr_i <= e.badv;
      we_i <= (e.op == op_write);
      waddr_i <= e.addr;
      wdata_i <= e.data;
      raddr_i <= (e.op == op_read) ? e.addr : 5'd0;
      exp_valid <= (e.op == op_read);
      exp_rdata <= e.data;
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("Something failed");
         $finish;
      end
   end

   initial begin
      {valid_i, in_delay_slot_i, we_i, exp_valid} = '0;
      {adel_i, ades_i, ri_i, sys_i, bp_i, ov_i, eret_i} = '0;
      {ext_int_i, pc_i, badvaddr_i, wdata_i, exp_rdata, waddr_i, raddr_i} = '0;
      tb_errors = 0;
      cycles = 0;
      rst = 1'b1;
      build_table();
      limit = table_q.size() * 4 + 200;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      foreach (table_q[i]) begin
         @(posedge clk);
         drive_entry(table_q[i]);
         if (table_q[i].op == op_wait) begin
            n = 0;
            while (!timer_int_o && n < table_q[i].data) begin
               @(posedge clk);
               n++;
            end
            if (!timer_int_o) begin
               tb_errors++;
               $display("timer interrupt did not rise within %0d cycles", table_q[i].data);
            end
         end
      end
      @(posedge clk);
      drive_entry('{op_idle, 0, 0, 0, 0, 0, 0, 0});
      repeat (3) @(posedge clk);
      $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
      if (checker_errors + tb_errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
source/cp0_pkg.sv
source/exc_commit_if.sv
source/int_ctrl.sv
source/exc_arbiter.sv
source/cp0_reg.sv
source/cp0_top.sv
sim/cp0_checker.sv
sim/cp0_tb.sv

// ==== Bender.yml ====
package:
  name: cp0

sources:
  - source/cp0_pkg.sv
  - source/exc_commit_if.sv
  - source/int_ctrl.sv
  - source/exc_arbiter.sv
  - source/cp0_reg.sv
  - source/cp0_top.sv
  - target: simulation
    files:
      - sim/cp0_checker.sv
      - sim/cp0_tb.sv
